/* common/ex_pkg.sv */
// execute stage package with word widths, operation codes and result classes
`default_nettype none

package ex_pkg;

    localparam int word_w    = 32;
    localparam int dword_w   = 2 * word_w;
    localparam int regaddr_w = 5;
    localparam int shamt_w   = 5;
    localparam int aluop_w   = 8;
    localparam int alusel_w  = 3;

    // logic
    localparam logic [aluop_w-1:0] op_nop   = 8'b0000_0000;
    localparam logic [aluop_w-1:0] op_and   = 8'b0010_0100;
    localparam logic [aluop_w-1:0] op_or    = 8'b0010_0101;
    localparam logic [aluop_w-1:0] op_xor   = 8'b0010_0110;
    localparam logic [aluop_w-1:0] op_nor   = 8'b0010_0111;

    // shifts
    localparam logic [aluop_w-1:0] op_sll   = 8'b0111_1100;
    localparam logic [aluop_w-1:0] op_srl   = 8'b0000_0010;
    localparam logic [aluop_w-1:0] op_sra   = 8'b0000_0011;

    // arithmetic
    localparam logic [aluop_w-1:0] op_slt   = 8'b0010_1010;
    localparam logic [aluop_w-1:0] op_sltu  = 8'b0010_1011;
    localparam logic [aluop_w-1:0] op_add   = 8'b0010_0000;
    localparam logic [aluop_w-1:0] op_addu  = 8'b0010_0001;
    localparam logic [aluop_w-1:0] op_sub   = 8'b0010_0010;
    localparam logic [aluop_w-1:0] op_subu  = 8'b0010_0011;
    localparam logic [aluop_w-1:0] op_addi  = 8'b0101_0101;
    localparam logic [aluop_w-1:0] op_addiu = 8'b0101_0110;
    localparam logic [aluop_w-1:0] op_clz   = 8'b1011_0000;
    localparam logic [aluop_w-1:0] op_clo   = 8'b1011_0001;

    // multiply
    localparam logic [aluop_w-1:0] op_mult  = 8'b0001_1000;
    localparam logic [aluop_w-1:0] op_multu = 8'b0001_1001;
    localparam logic [aluop_w-1:0] op_mul   = 8'b1010_1001;

    // hi/lo moves
    localparam logic [aluop_w-1:0] op_mfhi  = 8'b0001_0000;
    localparam logic [aluop_w-1:0] op_mthi  = 8'b0001_0001;
    localparam logic [aluop_w-1:0] op_mflo  = 8'b0001_0010;
    localparam logic [aluop_w-1:0] op_mtlo  = 8'b0001_0011;

    // result classes
    localparam logic [alusel_w-1:0] sel_nop   = 3'b000;
    localparam logic [alusel_w-1:0] sel_logic = 3'b001;
    localparam logic [alusel_w-1:0] sel_shift = 3'b010;
    localparam logic [alusel_w-1:0] sel_move  = 3'b011;
    localparam logic [alusel_w-1:0] sel_arith = 3'b100;
    localparam logic [alusel_w-1:0] sel_mul   = 3'b101;

    // full product or the hi/lo register pair
    typedef union packed {
        logic [dword_w-1:0] full;
        struct packed {
            logic [word_w-1:0] hi;
            logic [word_w-1:0] lo;
        } half;
    } hilo_word_u;

endpackage

`default_nettype wire

/* common/ex_operand_if.sv */
// operand bundle that carries one issued operation to the functional units
`timescale 1ns/100ps
`default_nettype none

interface ex_operand_if import ex_pkg::*; ();

    logic [aluop_w-1:0] aluop;
    logic [word_w-1:0]  reg1;
    logic [word_w-1:0]  reg2;
    // single-cycle strobe, fields are don't-care while low
    logic               issue;

    modport driver (
        output aluop,
        output reg1,
        output reg2,
        output issue
    );

    modport unit (
        input aluop,
        input reg1,
        input reg2,
        input issue
    );

endinterface

`default_nettype wire

/* source/ex_logic_shift.sv */
// bitwise logic and barrel shift unit of the execute stage
`timescale 1ns/100ps
`default_nettype none

module ex_logic_shift import ex_pkg::*; (
    ex_operand_if.unit        ops,
    output logic [word_w-1:0] result_o
);

    logic [shamt_w-1:0] shamt;

    // shift amount comes from the low bits of reg1
    assign shamt = ops.reg1[shamt_w-1:0];

    always_comb begin
        result_o = '0;
        if (ops.issue) begin
            case (ops.aluop)
                op_and: begin
                    result_o = ops.reg1 & ops.reg2;
                end
                op_or: begin
                    result_o = ops.reg1 | ops.reg2;
                end
                op_nor: begin
                    result_o = ~(ops.reg1 | ops.reg2);
                end
                op_xor: begin
                    result_o = ops.reg1 ^ ops.reg2;
                end
                op_sll: begin
                    result_o = ops.reg2 << shamt;
                end
                op_srl: begin
                    result_o = ops.reg2 >> shamt;
                end
                op_sra: begin
                    // sign fill from reg2
                    result_o = $signed(ops.reg2) >>> shamt;
                end
                default: begin
                    result_o = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* arith/ex_arith.sv */
// adder, set-less-than compare, overflow trap and leading zero/one counter
`timescale 1ns/100ps
`default_nettype none

module ex_arith import ex_pkg::*; (
    ex_operand_if.unit        ops,
    output logic [word_w-1:0] result_o,
    output logic              ovf_trap_o
);

    logic              is_sub;
    logic              is_trap_op;
    logic [word_w-1:0] reg2_mux;
    logic [word_w-1:0] sum;
    logic              ovf;
    logic              lt_signed;
    logic              lt_unsigned;

    // count of zero bits above the highest set bit
    function automatic logic [word_w-1:0] lead_zeros(input logic [word_w-1:0] v);
        logic [word_w-1:0] cnt;
        logic              hit;
        cnt = '0;
        hit = 1'b0;
        for (int i = word_w - 1; i >= 0; i--) begin
            if (v[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                cnt = cnt + 1'b1;
            end
        end
        return cnt;
    endfunction

    assign is_sub = (ops.aluop == op_sub) || (ops.aluop == op_subu)
                 || (ops.aluop == op_slt);

    // one adder subtracts through the two's complement of reg2
    assign reg2_mux = is_sub ? (~ops.reg2 + 1'b1) : ops.reg2;
    assign sum      = ops.reg1 + reg2_mux;

    // same effective operand signs but a flipped result sign
    assign ovf = (ops.reg1[word_w-1] == (ops.reg2[word_w-1] ^ is_sub))
              && (sum[word_w-1] != ops.reg1[word_w-1]);

    // negative against positive or else the sign of the difference
    assign lt_signed = (ops.reg1[word_w-1] && !ops.reg2[word_w-1])
                    || ((ops.reg1[word_w-1] == ops.reg2[word_w-1]) && sum[word_w-1]);
    assign lt_unsigned = ops.reg1 < ops.reg2;

    assign is_trap_op = (ops.aluop == op_add) || (ops.aluop == op_addi)
                     || (ops.aluop == op_sub);

    // only the trapping forms may suppress the write
    assign ovf_trap_o = ops.issue && is_trap_op && ovf;

    always_comb begin
        result_o = '0;
        if (ops.issue) begin
            case (ops.aluop)
                op_add, op_addu, op_addi, op_addiu, op_sub, op_subu: begin
                    result_o = sum;
                end
                op_slt: begin
                    result_o = word_w'(lt_signed);
                end
                op_sltu: begin
                    result_o = word_w'(lt_unsigned);
                end
                op_clz: begin
                    result_o = lead_zeros(ops.reg1);
                end
                op_clo: begin
                    // leading ones are the leading zeros of the inverse
                    result_o = lead_zeros(~ops.reg1);
                end
                default: begin
                    result_o = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/ex_multiplier.sv */
// 32 by 32 multiplier for signed and unsigned operands with sign correction
`timescale 1ns/100ps
`default_nettype none

module ex_multiplier import ex_pkg::*; (
    ex_operand_if.unit ops,
    output hilo_word_u product_o
);

    logic               is_signed;
    logic               negate;
    logic [word_w-1:0]  mcand;
    logic [word_w-1:0]  mplier;
    logic [dword_w-1:0] mag;

    assign is_signed = (ops.aluop == op_mul) || (ops.aluop == op_mult);

    // magnitudes of negative signed operands
    assign mcand  = (is_signed && ops.reg1[word_w-1]) ? (~ops.reg1 + 1'b1) : ops.reg1;
    assign mplier = (is_signed && ops.reg2[word_w-1]) ? (~ops.reg2 + 1'b1) : ops.reg2;

    assign mag = dword_w'(mcand) * dword_w'(mplier);

    // result is negative when operand signs differ
    assign negate = is_signed && (ops.reg1[word_w-1] ^ ops.reg2[word_w-1]);

    always_comb begin
        product_o.full = '0;
        if (ops.issue) begin
            product_o.full = negate ? (~mag + 1'b1) : mag;
        end
    end

    // unsigned high word stays at or below both factors
    always_comb begin
        if (ops.issue && (ops.aluop == op_multu)) begin
            assert final ((product_o.half.hi <= ops.reg1) && (product_o.half.hi <= ops.reg2))
                else $error("multu high word %h exceeds an operand (%h, %h)",
                            product_o.half.hi, ops.reg1, ops.reg2);
        end
    end

endmodule

`default_nettype wire

/* source/ex_hilo.sv */
// hi/lo register pair with its write decode and the move-from result
`timescale 1ns/100ps
`default_nettype none

module ex_hilo import ex_pkg::*; (
    input  logic              clk,
    input  logic              reset_i,
    ex_operand_if.unit        ops,
    input  hilo_word_u        product_i,
    output logic [word_w-1:0] move_o
);

    hilo_word_u hilo_q;
    logic       hilo_we;

    assign hilo_we = ops.issue
                  && ((ops.aluop == op_mult) || (ops.aluop == op_multu)
                   || (ops.aluop == op_mthi) || (ops.aluop == op_mtlo));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo_q <= '0;
        end else if (hilo_we) begin
            case (ops.aluop)
                op_mthi: begin
                    hilo_q.half.hi <= ops.reg1;
                end
                op_mtlo: begin
                    hilo_q.half.lo <= ops.reg1;
                end
                default: begin
                    // mult and multu load the whole product
                    hilo_q <= product_i;
                end
            endcase
        end
    end

    // read is combinational, a write is visible to the next issue
    always_comb begin
        move_o = '0;
        if (ops.issue) begin
            case (ops.aluop)
                op_mfhi: begin
                    move_o = hilo_q.half.hi;
                end
                op_mflo: begin
                    move_o = hilo_q.half.lo;
                end
                default: begin
                    move_o = '0;
                end
            endcase
        end
    end

    // pair holds unless a write-class op was issued
    assert property (@(posedge clk) disable iff (reset_i)
                     !hilo_we |=> $stable(hilo_q.full))
        else $error("hi/lo changed without a write-class operation");

endmodule

`default_nettype wire

/* source/ex_top.sv */
// execute stage top with functional units, result select and output register
`timescale 1ns/100ps
`default_nettype none

module ex_top import ex_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 issue_i,
    input  logic [aluop_w-1:0]   aluop_i,
    input  logic [alusel_w-1:0]  alusel_i,
    input  logic [word_w-1:0]    reg1_i,
    input  logic [word_w-1:0]    reg2_i,
    input  logic [regaddr_w-1:0] wd_i,
    input  logic                 wreg_i,
    output logic                 valid_o,
    output logic [regaddr_w-1:0] wd_o,
    output logic                 wreg_o,
    output logic [word_w-1:0]    wdata_o
);

    logic [word_w-1:0] ls_res;
    logic [word_w-1:0] arith_res;
    logic [word_w-1:0] move_res;
    logic [word_w-1:0] wdata_next;
    logic              ovf_trap;
    logic              wreg_next;
    hilo_word_u        product;

    ex_operand_if u_ops ();

    assign u_ops.aluop = aluop_i;
    assign u_ops.reg1  = reg1_i;
    assign u_ops.reg2  = reg2_i;
    assign u_ops.issue = issue_i;

    ex_logic_shift u_logic_shift (
        .ops      (u_ops.unit),
        .result_o (ls_res)
    );

    ex_arith u_arith (
        .ops        (u_ops.unit),
        .result_o   (arith_res),
        .ovf_trap_o (ovf_trap)
    );

    ex_multiplier u_multiplier (
        .ops       (u_ops.unit),
        .product_o (product)
    );

    ex_hilo u_hilo (
        .clk       (clk),
        .reset_i   (reset_i),
        .ops       (u_ops.unit),
        .product_i (product),
        .move_o    (move_res)
    );

    // write-back data by result class
    always_comb begin
        case (alusel_i)
            sel_logic, sel_shift: begin
                wdata_next = ls_res;
            end
            sel_arith: begin
                wdata_next = arith_res;
            end
            sel_move: begin
                wdata_next = move_res;
            end
            sel_mul: begin
                wdata_next = product.half.lo;
            end
            default: begin
                wdata_next = '0;
            end
        endcase
    end

    // overflow trap drops the register write
    assign wreg_next = wreg_i && !ovf_trap;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
        end else begin
            valid_o <= issue_i;
            wreg_o  <= issue_i && wreg_next;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            wd_o    <= wd_i;
            wdata_o <= wdata_next;
        end
    end

    // no result may leave in the cycle after a reset
    assert property (@(posedge clk) reset_i |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

endmodule

`default_nettype wire

/* sim/tb_ex_vectors.svh */
// directed stimulus and expected values for the execute stage testbench
`ifndef TB_EX_VECTORS_SVH
`define TB_EX_VECTORS_SVH

// each row gives name, aluop, alusel, reg1, reg2, wd, wreg, expected wreg and expected data
task automatic fill_table();
    // hi/lo start at zero
    add_row("mfhi_reset", op_mfhi, sel_move, 32'h0000_0000, 32'h0, 5'd1, 1'b1, 1'b1, 32'h0);
    add_row("mflo_reset", op_mflo, sel_move, 32'h0000_0000, 32'h0, 5'd2, 1'b1, 1'b1, 32'h0);
    add_row("and", op_and, sel_logic, 32'hf0f0_f0f0, 32'hff00_ff00, 5'd3, 1'b1, 1'b1, 32'hf000_f000);
    add_row("or", op_or, sel_logic, 32'hf0f0_f0f0, 32'hff00_ff00, 5'd4, 1'b1, 1'b1, 32'hfff0_fff0);
    add_row("nor", op_nor, sel_logic, 32'hf0f0_f0f0, 32'hff00_ff00, 5'd5, 1'b1, 1'b1, 32'h000f_000f);
    add_row("xor", op_xor, sel_logic, 32'hf0f0_f0f0, 32'hff00_ff00, 5'd6, 1'b1, 1'b1, 32'h0ff0_0ff0);
    // reg1 holds the shift amount
    add_row("sll_4", op_sll, sel_shift, 32'd4, 32'h1234_5678, 5'd7, 1'b1, 1'b1, 32'h2345_6780);
    add_row("srl_8", op_srl, sel_shift, 32'd8, 32'h8000_0000, 5'd8, 1'b1, 1'b1, 32'h0080_0000);
    add_row("sra_0", op_sra, sel_shift, 32'd0, 32'h8000_0001, 5'd9, 1'b1, 1'b1, 32'h8000_0001);
    add_row("sra_31", op_sra, sel_shift, 32'd31, 32'h8000_0000, 5'd10, 1'b1, 1'b1, 32'hffff_ffff);
    add_row("sra_4", op_sra, sel_shift, 32'd4, 32'hf000_0000, 5'd11, 1'b1, 1'b1, 32'hff00_0000);
    // signed overflow drops the write
    add_row("add_ovf", op_add, sel_arith, 32'h7fff_ffff, 32'h1, 5'd12, 1'b1, 1'b0, 32'h8000_0000);
    add_row("addi_ovf", op_addi, sel_arith, 32'h7fff_ffff, 32'h1, 5'd13, 1'b1, 1'b0, 32'h8000_0000);
    add_row("sub_ovf", op_sub, sel_arith, 32'h8000_0000, 32'h1, 5'd14, 1'b1, 1'b0, 32'h7fff_ffff);
    // most negative subtrahend
    add_row("sub_min_ovf", op_sub, sel_arith, 32'h0, 32'h8000_0000, 5'd2, 1'b1, 1'b0, 32'h8000_0000);
    add_row("sub_min_ok", op_sub, sel_arith, 32'hffff_ffff, 32'h8000_0000, 5'd3, 1'b1, 1'b1,
            32'h7fff_ffff);
    add_row("addu_wrap", op_addu, sel_arith, 32'h7fff_ffff, 32'h1, 5'd15, 1'b1, 1'b1, 32'h8000_0000);
    add_row("subu_wrap", op_subu, sel_arith, 32'h8000_0000, 32'h1, 5'd16, 1'b1, 1'b1, 32'h7fff_ffff);
    add_row("addiu", op_addiu, sel_arith, 32'd5, 32'd3, 5'd17, 1'b1, 1'b1, 32'd8);
    add_row("slt_neg", op_slt, sel_arith, 32'hffff_ffff, 32'h1, 5'd18, 1'b1, 1'b1, 32'd1);
    add_row("sltu_neg", op_sltu, sel_arith, 32'hffff_ffff, 32'h1, 5'd19, 1'b1, 1'b1, 32'd0);
    add_row("clz_zero", op_clz, sel_arith, 32'h0, 32'h0, 5'd20, 1'b1, 1'b1, 32'd32);
    add_row("clz_ones", op_clz, sel_arith, 32'hffff_ffff, 32'h0, 5'd21, 1'b1, 1'b1, 32'd0);
    add_row("clo_ones", op_clo, sel_arith, 32'hffff_ffff, 32'h0, 5'd22, 1'b1, 1'b1, 32'd32);
    add_row("clo_zero", op_clo, sel_arith, 32'h0, 32'h0, 5'd23, 1'b1, 1'b1, 32'd0);
    // -1 * 2 into hi/lo
    add_row("mult", op_mult, sel_nop, 32'hffff_ffff, 32'd2, 5'd0, 1'b0, 1'b0, 32'h0);
    add_row("mfhi_mult", op_mfhi, sel_move, 32'h0, 32'h0, 5'd24, 1'b1, 1'b1, 32'hffff_ffff);
    add_row("mflo_mult", op_mflo, sel_move, 32'h0, 32'h0, 5'd25, 1'b1, 1'b1, 32'hffff_fffe);
    add_row("multu", op_multu, sel_nop, 32'hffff_ffff, 32'd2, 5'd0, 1'b0, 1'b0, 32'h0);
    add_row("mfhi_multu", op_mfhi, sel_move, 32'h0, 32'h0, 5'd26, 1'b1, 1'b1, 32'h0000_0001);
    add_row("mflo_multu", op_mflo, sel_move, 32'h0, 32'h0, 5'd27, 1'b1, 1'b1, 32'hffff_fffe);
    add_row("mul_mixed", op_mul, sel_mul, 32'hffff_fffd, 32'd7, 5'd28, 1'b1, 1'b1, 32'hffff_ffeb);
    add_row("mul_wrap", op_mul, sel_mul, 32'h0001_0000, 32'h0001_0000, 5'd29, 1'b1, 1'b1, 32'h0);
    add_row("mthi", op_mthi, sel_nop, 32'hcafe_0001, 32'h0, 5'd0, 1'b0, 1'b0, 32'h0);
    add_row("mflo_kept", op_mflo, sel_move, 32'h0, 32'h0, 5'd30, 1'b1, 1'b1, 32'hffff_fffe);
    add_row("mfhi_new", op_mfhi, sel_move, 32'h0, 32'h0, 5'd31, 1'b1, 1'b1, 32'hcafe_0001);
    add_row("mtlo", op_mtlo, sel_nop, 32'h0000_0055, 32'h0, 5'd0, 1'b0, 1'b0, 32'h0);
    add_row("mflo_new", op_mflo, sel_move, 32'h0, 32'h0, 5'd1, 1'b1, 1'b1, 32'h0000_0055);
endtask

`endif

/* sim/tb_ex_top.sv */
// testbench for the execute stage with directed table, random rows and back-to-back issue
`timescale 1ns/100ps
`default_nettype none

module tb_ex_top import ex_pkg::*; ();

    localparam int wait_limit = 20;
    localparam int rand_rows  = 24;

    typedef struct packed {
        logic [aluop_w-1:0]   op;
        logic [alusel_w-1:0]  sel;
        logic [word_w-1:0]    r1;
        logic [word_w-1:0]    r2;
        logic [regaddr_w-1:0] wd;
        logic                 wreg;
        logic                 exp_wreg;
        logic [word_w-1:0]    exp_data;
    } vec_t;

    logic                 clk;
    logic                 reset_i;
    logic                 issue_i;
    logic [aluop_w-1:0]   aluop_i;
    logic [alusel_w-1:0]  alusel_i;
    logic [word_w-1:0]    reg1_i;
    logic [word_w-1:0]    reg2_i;
    logic [regaddr_w-1:0] wd_i;
    logic                 wreg_i;
    logic                 valid_o;
    logic [regaddr_w-1:0] wd_o;
    logic                 wreg_o;
    logic [word_w-1:0]    wdata_o;

    vec_t        rows[$];
    string       names[$];
    logic [31:0] lcg_state;
    int          n_tests;
    int          n_fail;
    bit          hung;

    ex_top u_dut (
        .clk      (clk),
        .reset_i  (reset_i),
        .issue_i  (issue_i),
        .aluop_i  (aluop_i),
        .alusel_i (alusel_i),
        .reg1_i   (reg1_i),
        .reg2_i   (reg2_i),
        .wd_i     (wd_i),
        .wreg_i   (wreg_i),
        .valid_o  (valid_o),
        .wd_o     (wd_o),
        .wreg_o   (wreg_o),
        .wdata_o  (wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic add_row(input string name, input logic [aluop_w-1:0] op,
                           input logic [alusel_w-1:0] sel, input logic [word_w-1:0] r1,
                           input logic [word_w-1:0] r2, input logic [regaddr_w-1:0] wd,
                           input logic wreg, input logic exp_wreg,
                           input logic [word_w-1:0] exp_data);
        vec_t v;
        v = '{op, sel, r1, r2, wd, wreg, exp_wreg, exp_data};
        rows.push_back(v);
        names.push_back(name);
    endtask

    `include "tb_ex_vectors.svh"

    function automatic logic [alusel_w-1:0] class_of(input logic [aluop_w-1:0] op);
        case (op)
            op_and, op_or, op_xor, op_nor: return sel_logic;
            op_sll, op_srl, op_sra: return sel_shift;
            op_mul: return sel_mul;
            default: return sel_arith;
        endcase
    endfunction

    // reference model of the write-back data
    function automatic logic [word_w-1:0] model_data(input logic [aluop_w-1:0] op,
                                                     input logic [word_w-1:0] a,
                                                     input logic [word_w-1:0] b);
        int n;
        case (op)
            op_and: return a & b;
            op_or: return a | b;
            op_xor: return a ^ b;
            op_nor: return ~(a | b);
            op_sll: return b << a[4:0];
            op_srl: return b >> a[4:0];
            op_sra: return $signed(b) >>> a[4:0];
            op_add, op_addu: return a + b;
            op_sub, op_subu: return a - b;
            op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            op_clz, op_clo: begin
                n = 0;
                while (n < 32 && a[31-n] == (op == op_clo)) begin
                    n++;
                end
                return n;
            end
            op_mul: return a * b;
            default: return '0;
        endcase
    endfunction

    function automatic logic model_wreg(input logic [aluop_w-1:0] op,
                                        input logic [word_w-1:0] a,
                                        input logic [word_w-1:0] b, input logic wreg);
        longint s;
        s = 0;
        if (op == op_add) begin
            s = longint'($signed(a)) + longint'($signed(b));
        end
        if (op == op_sub) begin
            s = longint'($signed(a)) - longint'($signed(b));
        end
        if (s > 64'sd2147483647 || s < -64'sd2147483648) begin
            return 1'b0;
        end
        return wreg;
    endfunction

    task automatic drive(input vec_t v);
        issue_i  = 1'b1;
        aluop_i  = v.op;
        alusel_i = v.sel;
        reg1_i   = v.r1;
        reg2_i   = v.r2;
        wd_i     = v.wd;
        wreg_i   = v.wreg;
    endtask

    task automatic compare(input string name, input vec_t v);
        n_tests++;
        if (wdata_o !== v.exp_data) begin
            $display("mismatch %s data: expected %h, actual %h", name, v.exp_data, wdata_o);
            n_fail++;
        end else if (wreg_o !== v.exp_wreg) begin
            $display("mismatch %s wreg: expected %b, actual %b", name, v.exp_wreg, wreg_o);
            n_fail++;
        end else if (wd_o !== v.wd) begin
            $display("mismatch %s wd: expected %0d, actual %0d", name, v.wd, wd_o);
            n_fail++;
        end else begin
            $display("ok %s", name);
        end
    endtask

    task automatic run_row(input string name, input vec_t v);
        int t;
        @(negedge clk);
        drive(v);
        @(negedge clk);
        issue_i = 1'b0;
        t = 0;
        while (!valid_o && t < wait_limit) begin
            @(negedge clk);
            t++;
        end
        if (!valid_o) begin
            $display("timeout in %s: valid_o never came", name);
            n_tests++;
            n_fail++;
            hung = 1'b1;
        end else begin
            compare(name, v);
        end
    endtask

    // three issues on consecutive cycles give one result per cycle in order
    task automatic run_back_to_back();
        vec_t v[3];
        logic [aluop_w-1:0] ops[3];
        ops = '{op_and, op_xor, op_addu};
        for (int i = 0; i < 3; i++) begin
            v[i].op       = ops[i];
            v[i].sel      = class_of(ops[i]);
            v[i].r1       = lcg_next();
            v[i].r2       = lcg_next();
            v[i].wd       = 5'(i + 1);
            v[i].wreg     = 1'b1;
            v[i].exp_wreg = 1'b1;
            v[i].exp_data = model_data(ops[i], v[i].r1, v[i].r2);
        end
        for (int i = 0; i <= 3; i++) begin
            @(negedge clk);
            if (i > 0) begin
                if (!valid_o) begin
                    $display("back_to_back_%0d: valid_o missing in its cycle", i - 1);
                    n_tests++;
                    n_fail++;
                end else begin
                    compare($sformatf("back_to_back_%0d", i - 1), v[i-1]);
                end
            end
            if (i < 3) begin
                drive(v[i]);
            end else begin
                issue_i = 1'b0;
            end
        end
    endtask

    initial begin
        vec_t rv;
        logic [31:0] draw;
        logic [aluop_w-1:0] pick[16];
        pick = '{op_and, op_or, op_xor, op_nor, op_sll, op_srl, op_sra, op_add,
                 op_addu, op_sub, op_subu, op_slt, op_sltu, op_clz, op_clo, op_mul};
        lcg_state = 32'hdf45;
        n_tests   = 0;
        n_fail    = 0;
        hung      = 1'b0;
        reset_i   = 1'b1;
        issue_i   = 1'b0;
        aluop_i   = op_nop;
        alusel_i  = sel_nop;
        reg1_i    = '0;
        reg2_i    = '0;
        wd_i      = '0;
        wreg_i    = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        @(negedge clk);
        n_tests++;
        if (valid_o !== 1'b0 || wreg_o !== 1'b0) begin
            $display("valid_o or wreg_o not low after reset");
            n_fail++;
        end else begin
            $display("ok reset_outputs");
        end
        fill_table();
        for (int i = 0; i < rows.size() && !hung; i++) begin
            run_row(names[i], rows[i]);
        end
        for (int i = 0; i < rand_rows && !hung; i++) begin
            // upper bits of the generator spread evenly over the op list
            draw        = lcg_next();
            rv.op       = pick[draw[31:28]];
            rv.sel      = class_of(rv.op);
            rv.r1       = lcg_next();
            rv.r2       = lcg_next();
            rv.wd       = 5'(lcg_next());
            rv.wreg     = 1'b1;
            rv.exp_wreg = model_wreg(rv.op, rv.r1, rv.r2, rv.wreg);
            rv.exp_data = model_data(rv.op, rv.r1, rv.r2);
            run_row($sformatf("random_%0d", i), rv);
        end
        if (!hung) begin
            run_back_to_back();
        end
        $display("tests %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+sim
common/ex_pkg.sv
common/ex_operand_if.sv
source/ex_logic_shift.sv
arith/ex_arith.sv
source/ex_multiplier.sv
source/ex_hilo.sv
source/ex_top.sv
sim/tb_ex_top.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_top
RTL_TOP   ?= ex_top
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
